//--- compactor_defines.svh
`ifndef COMPACTOR_DEFINES_SVH
`define COMPACTOR_DEFINES_SVH

// mask lanes, power of two only
`define CMP_DIMM 16

// result slots, at most CMP_DIMM
`define CMP_NUM_LR 4

// lane index width
`define CMP_IDX_W ($clog2(`CMP_DIMM))

// one stride stage per index bit
`define CMP_STAGES (`CMP_IDX_W)

// outlier count, wide enough for an all-ones mask
`define CMP_CNT_W (`CMP_IDX_W + 1)

// packed lane payload: occupied + idx + shift
`define CMP_LANE_W (1 + 2 * `CMP_IDX_W)

`endif

//--- cmpPkg.sv
`include "compactor_defines.svh"

package cmpPkg;

    // original lane number of an outlier
    typedef logic [`CMP_IDX_W-1:0] idxT;

    // remaining distance toward lane 0
    // bit j is consumed by stage j
    typedef logic [`CMP_IDX_W-1:0] shiftT;

    // total outliers in one mask
    typedef logic [`CMP_CNT_W-1:0] cntT;

    // one lane of the compaction network
    typedef struct packed {
        // lane carries an outlier
        logic  occupied;
        // where the outlier started
        idxT   idx;
        // inliers still to skip over
        shiftT shift;
    } laneT;

endpackage

//--- outlierTagger.sv
`timescale 1ns/1ps
`include "compactor_defines.svh"

module outlierTagger (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                inVld,
    input  logic [`CMP_DIMM-1:0]                mask,
    output logic                                tagVld,
    output cmpPkg::laneT [`CMP_DIMM-1:0]        lanes,
    output cmpPkg::cntT                         outlierCnt
);

    // next-state lane tags
    cmpPkg::laneT [`CMP_DIMM-1:0] nxtLanes;
    // running inlier count while walking up the mask
    cmpPkg::cntT                  zeroRun;
    cmpPkg::cntT                  nxtCnt;

    // lane registers
    logic [`CMP_DIMM-1:0]         occReg;
    cmpPkg::idxT                  idxReg   [`CMP_DIMM];
    cmpPkg::shiftT                shiftReg [`CMP_DIMM];

    // prefix count of zero bits below each lane
    // this is the distance each outlier has to travel down
    always_comb begin
        zeroRun = '0;
        for (int i = 0; i < `CMP_DIMM; i++) begin
            nxtLanes[i].occupied = mask[i];
            nxtLanes[i].idx      = cmpPkg::idxT'(i);
            nxtLanes[i].shift    = cmpPkg::shiftT'(zeroRun);
            zeroRun              = zeroRun + cmpPkg::cntT'(!mask[i]);
        end
        // whatever is not an inlier is an outlier
        nxtCnt = cmpPkg::cntT'(`CMP_DIMM) - zeroRun;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            tagVld <= 1'b0;
            occReg <= '0;
        end else begin
            tagVld <= inVld;
            if (inVld) begin
                for (int i = 0; i < `CMP_DIMM; i++) begin
                    occReg[i] <= nxtLanes[i].occupied;
                end
            end
        end
    end

    // payload only loads with a strobe
    always_ff @(posedge clk) begin
        if (inVld) begin
            for (int i = 0; i < `CMP_DIMM; i++) begin
                idxReg[i]   <= nxtLanes[i].idx;
                shiftReg[i] <= nxtLanes[i].shift;
            end
            outlierCnt <= nxtCnt;
        end
    end

    // repack into lane structs for stage 0
    for (genvar i = 0; i < `CMP_DIMM; i++) begin : gPack
        assign lanes[i].occupied = occReg[i];
        assign lanes[i].idx      = idxReg[i];
        assign lanes[i].shift    = shiftReg[i];
    end

endmodule

//--- compactStage.sv
`timescale 1ns/1ps
`include "compactor_defines.svh"

module compactStage #(
    parameter int STRIDE_LOG = 0
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                stgInVld,
    input  cmpPkg::laneT [`CMP_DIMM-1:0]        stgIn,
    input  cmpPkg::cntT                         cntIn,
    output logic                                stgOutVld,
    output cmpPkg::laneT [`CMP_DIMM-1:0]        stgOut,
    output cmpPkg::cntT                         cntOut
);

    // items move down by this many lanes when their shift bit is set
    localparam int STRIDE = 1 << STRIDE_LOG;

    cmpPkg::laneT [`CMP_DIMM-1:0] nxtLanes;

    logic [`CMP_DIMM-1:0]         occReg;
    cmpPkg::idxT                  idxReg   [`CMP_DIMM];
    cmpPkg::shiftT                shiftReg [`CMP_DIMM];

    for (genvar i = 0; i < `CMP_DIMM; i++) begin : gLane
        // own item stays when its bit is clear
        logic         keepOwn;
        // item from above arrives when its bit is set
        logic         takeUp;
        cmpPkg::laneT upItem;

        assign keepOwn = stgIn[i].occupied && !stgIn[i].shift[STRIDE_LOG];

        if (i + STRIDE < `CMP_DIMM) begin : gUp
            assign upItem = stgIn[i+STRIDE];
            assign takeUp = stgIn[i+STRIDE].occupied && stgIn[i+STRIDE].shift[STRIDE_LOG];
        end else begin : gTop
            // nothing above the top lanes
            assign upItem = '0;
            assign takeUp = 1'b0;
        end

        // a lane whose item left and got nothing in return goes empty
        assign nxtLanes[i] = takeUp ? upItem : (keepOwn ? stgIn[i] : '0);

        // LSB-first strides with a monotone prefix count never collide
        // a hit here means the tagger's shift values are broken
        noCollision: assert property (
            @(posedge clk) disable iff (!rstN)
            stgInVld |-> !(takeUp && keepOwn)
        );

        assign stgOut[i].occupied = occReg[i];
        assign stgOut[i].idx      = idxReg[i];
        assign stgOut[i].shift    = shiftReg[i];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stgOutVld <= 1'b0;
            occReg    <= '0;
        end else begin
            stgOutVld <= stgInVld;
            if (stgInVld) begin
                for (int i = 0; i < `CMP_DIMM; i++) begin
                    occReg[i] <= nxtLanes[i].occupied;
                end
            end
        end
    end

    // count rides along unchanged
    always_ff @(posedge clk) begin
        if (stgInVld) begin
            for (int i = 0; i < `CMP_DIMM; i++) begin
                idxReg[i]   <= nxtLanes[i].idx;
                shiftReg[i] <= nxtLanes[i].shift;
            end
            cntOut <= cntIn;
        end
    end

endmodule

//--- indexCollector.sv
`timescale 1ns/1ps
`include "compactor_defines.svh"

module indexCollector (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                colInVld,
    input  cmpPkg::laneT [`CMP_DIMM-1:0]        lanes,
    input  cmpPkg::cntT                         cntIn,
    output logic                                outVld,
    output cmpPkg::idxT [`CMP_NUM_LR-1:0]       idxOut,
    output logic [`CMP_NUM_LR-1:0]              slotVld,
    output cmpPkg::cntT                         outlierCnt
);

    // occupancy of every lane after the last stride
    logic [`CMP_DIMM-1:0] occVec;

    for (genvar i = 0; i < `CMP_DIMM; i++) begin : gOcc
        assign occVec[i] = lanes[i].occupied;
    end

    // compacted lanes must look like 0..01..1 from the top down
    // and hold exactly as many items as the tagger counted
    packedOutliers: assert property (
        @(posedge clk) disable iff (!rstN)
        colInVld |-> (((occVec & (occVec + 1'b1)) == '0) &&
                      ($countones(occVec) == int'(cntIn)))
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outVld  <= 1'b0;
            slotVld <= '0;
        end else begin
            outVld <= colInVld;
            if (colInVld) begin
                // only the lowest lanes become result slots
                slotVld <= occVec[`CMP_NUM_LR-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (colInVld) begin
            for (int k = 0; k < `CMP_NUM_LR; k++) begin
                // empty slot reports index zero
                idxOut[k] <= lanes[k].occupied ? lanes[k].idx : '0;
            end
            outlierCnt <= cntIn;
        end
    end

endmodule

//--- outlierCompactor.sv
`timescale 1ns/1ps
`include "compactor_defines.svh"

module outlierCompactor (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  logic                                        inVld,
    input  logic [`CMP_DIMM-1:0]                        mask,
    output logic                                        outVld,
    output logic [`CMP_NUM_LR-1:0][`CMP_IDX_W-1:0]      idxOut,
    output logic [`CMP_NUM_LR-1:0]                      slotVld,
    output logic [`CMP_CNT_W-1:0]                       outlierCnt
);

    // entry 0 is the tagger output, entry j+1 is stage j output
    logic [`CMP_DIMM-1:0][`CMP_LANE_W-1:0] chainLanes [`CMP_STAGES+1];
    logic [`CMP_STAGES:0]                  chainVld;
    logic [`CMP_CNT_W-1:0]                 chainCnt   [`CMP_STAGES+1];

    outlierTagger uTagger (
        .clk        (clk),
        .rstN       (rstN),
        .inVld      (inVld),
        .mask       (mask),
        .tagVld     (chainVld[0]),
        .lanes      (chainLanes[0]),
        .outlierCnt (chainCnt[0])
    );

    // stride 1, 2, 4 ... one register each
    for (genvar j = 0; j < `CMP_STAGES; j++) begin : gStage
        compactStage #(
            .STRIDE_LOG (j)
        ) uStage (
            .clk       (clk),
            .rstN      (rstN),
            .stgInVld  (chainVld[j]),
            .stgIn     (chainLanes[j]),
            .cntIn     (chainCnt[j]),
            .stgOutVld (chainVld[j+1]),
            .stgOut    (chainLanes[j+1]),
            .cntOut    (chainCnt[j+1])
        );
    end

    indexCollector uCollector (
        .clk        (clk),
        .rstN       (rstN),
        .colInVld   (chainVld[`CMP_STAGES]),
        .lanes      (chainLanes[`CMP_STAGES]),
        .cntIn      (chainCnt[`CMP_STAGES]),
        .outVld     (outVld),
        .idxOut     (idxOut),
        .slotVld    (slotVld),
        .outlierCnt (outlierCnt)
    );

endmodule

//--- tbOutlierCompactor.sv
`timescale 1ns/1ps
`include "compactor_defines.svh"

module tbOutlierCompactor;

    // stimulus lengths, also used to size the watchdog
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 12;
    localparam int RANDOM_COUNT = 200;
    localparam int GAP_COUNT    = 40;
    localparam int MAX_GAP      = 3;
    localparam int LATENCY      = `CMP_STAGES + 2;
    localparam int DRAIN_LIMIT  = LATENCY + 10;
    localparam int VECTORS      = IDLE_CYCLES + 4 + 4 + RANDOM_COUNT
                                  + GAP_COUNT * (MAX_GAP + 1);
    localparam int LIMIT_CYCLES = RESET_CYCLES + 2 + VECTORS + 5 * DRAIN_LIMIT + 20;

    logic                                   clk   = 1'b0;
    logic                                   rstN  = 1'b0;
    logic                                   inVld = 1'b0;
    logic [`CMP_DIMM-1:0]                   mask  = '0;
    logic                                   outVld;
    logic [`CMP_NUM_LR-1:0][`CMP_IDX_W-1:0] idxOut;
    logic [`CMP_NUM_LR-1:0]                 slotVld;
    logic [`CMP_CNT_W-1:0]                  outlierCnt;

    // strobes waiting for their result, with the edge the DUT sampled them
    logic [`CMP_DIMM-1:0] expMasks [$];
    int                   expIssue [$];

    int          cycle       = 0;
    int          strobeTotal = 0;
    int          pulseTotal  = 0;
    // monitor and test process keep separate error tallies
    int          monErrs     = 0;
    int          tbErrs      = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    string       testName    = "reset";
    logic [31:0] lcgState    = 32'hac76_57c8;

    outlierCompactor DUT (
        .clk        (clk),
        .rstN       (rstN),
        .inVld      (inVld),
        .mask       (mask),
        .outVld     (outVld),
        .idxOut     (idxOut),
        .slotVld    (slotVld),
        .outlierCnt (outlierCnt)
    );

    always #5 clk = ~clk;

    // edge counter for latency checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drawRandom(output logic [31:0] r);
        lcgState = lcgNext(lcgState);
        r = lcgState;
    endtask

    // lowest set bits first, unused slots stay zero and invalid
    function automatic void refModel(
        input  logic [`CMP_DIMM-1:0]           m,
        output cmpPkg::idxT [`CMP_NUM_LR-1:0] idx,
        output logic [`CMP_NUM_LR-1:0]        vld,
        output cmpPkg::cntT                   cnt
    );
        int k;
        k   = 0;
        idx = '0;
        vld = '0;
        for (int i = 0; i < `CMP_DIMM; i++) begin
            if (m[i]) begin
                if (k < `CMP_NUM_LR) begin
                    idx[k] = cmpPkg::idxT'(i);
                    vld[k] = 1'b1;
                end
                k++;
            end
        end
        cnt = cmpPkg::cntT'(k);
    endfunction

    function automatic logic [`CMP_DIMM-1:0] laneBit(input int lane);
        logic [`CMP_DIMM-1:0] m;
        m       = '0;
        m[lane] = 1'b1;
        return m;
    endfunction

    task automatic checkIdx(input string name, input int slot,
                            input cmpPkg::idxT exp, input cmpPkg::idxT act);
        if (exp !== act) begin
            monErrs++;
            $display("ERR %s slot %0d idx expected %0d actual %0d", name, slot, exp, act);
        end
    endtask

    task automatic checkCnt(input string name, input cmpPkg::cntT exp, input cmpPkg::cntT act);
        if (exp !== act) begin
            monErrs++;
            $display("ERR %s count expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic checkSlots(input string name, input logic [`CMP_NUM_LR-1:0] exp,
                              input logic [`CMP_NUM_LR-1:0] act);
        if (exp !== act) begin
            monErrs++;
            $display("ERR %s slotVld expected %b actual %b", name, exp, act);
        end
    endtask

    // outputs are read on the edge, so they hold last cycle's registered values
    always @(posedge clk) begin : resultMonitor
        logic [`CMP_DIMM-1:0]          m;
        int                            iss;
        cmpPkg::idxT [`CMP_NUM_LR-1:0] eIdx;
        logic [`CMP_NUM_LR-1:0]        eVld;
        cmpPkg::cntT                   eCnt;
        if (outVld === 1'b1) begin
            pulseTotal = pulseTotal + 1;
            if (expMasks.size() == 0) begin
                monErrs++;
                $display("%s: outVld pulsed with no strobe pending", testName);
            end else begin
                m   = expMasks.pop_front();
                iss = expIssue.pop_front();
                refModel(m, eIdx, eVld, eCnt);
                for (int k = 0; k < `CMP_NUM_LR; k++) begin
                    checkIdx(testName, k, eIdx[k], idxOut[k]);
                end
                checkSlots(testName, eVld, slotVld);
                checkCnt(testName, eCnt, outlierCnt);
                if (cycle - iss != LATENCY) begin
                    monErrs++;
                    $display("%s: result for mask %h came %0d cycles after its strobe, not %0d",
                             testName, m, cycle - iss, LATENCY);
                end
            end
        end
    end

    // strobe goes high now, the DUT samples it on the next edge
    task automatic sendMask(input logic [`CMP_DIMM-1:0] m);
        @(posedge clk);
        inVld <= 1'b1;
        mask  <= m;
        expMasks.push_back(m);
        expIssue.push_back(cycle + 1);
        strobeTotal++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            inVld <= 1'b0;
        end
    endtask

    task automatic drainResults;
        int waited;
        waited = 0;
        while (expMasks.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            inVld <= 1'b0;
            waited++;
        end
        if (expMasks.size() != 0) begin
            tbErrs++;
            $display("%s: %0d results never came out", testName, expMasks.size());
        end
    endtask

    task automatic finishTest(input int errsBefore);
        int errs;
        errs = monErrs + tbErrs - errsBefore;
        if (errs == 0) begin
            testsPassed++;
            $display("PASS %s", testName);
        end else begin
            testsFailed++;
            $display("FAIL %s with %0d errors", testName, errs);
        end
    endtask

    // outVld must read a clean low on every idle edge
    task automatic idleAfterReset;
        int errsBefore;
        errsBefore = monErrs + tbErrs;
        testName   = "idleAfterReset";
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            inVld <= 1'b0;
            if (outVld !== 1'b0) begin
                tbErrs++;
                $display("%s: outVld is not low while no strobe was sent", testName);
            end
        end
        finishTest(errsBefore);
    endtask

    task automatic directedMasks;
        int errsBefore;
        errsBefore = monErrs + tbErrs;
        testName   = "directedMasks";
        sendMask('0);
        sendMask('1);
        sendMask(laneBit(`CMP_DIMM - 1));
        sendMask({(`CMP_DIMM / 2){2'b10}});
        drainResults();
        finishTest(errsBefore);
    endtask

    // fewer outliers than slots
    task automatic sparseMasks;
        int errsBefore;
        errsBefore = monErrs + tbErrs;
        testName   = "sparseMasks";
        sendMask(laneBit(0));
        idleCycles(2);
        sendMask(laneBit(0) | laneBit(`CMP_DIMM / 2));
        sendMask(laneBit(1) | laneBit(`CMP_DIMM / 4) | laneBit(`CMP_DIMM - 2));
        sendMask(laneBit(`CMP_DIMM - 1));
        drainResults();
        finishTest(errsBefore);
    endtask

    task automatic backToBackRandom;
        int          errsBefore;
        logic [31:0] r;
        errsBefore = monErrs + tbErrs;
        testName   = "backToBackRandom";
        repeat (RANDOM_COUNT) begin
            drawRandom(r);
            sendMask(`CMP_DIMM'(r >> (32 - `CMP_DIMM)));
        end
        drainResults();
        finishTest(errsBefore);
    endtask

    task automatic gappedRandom;
        int          errsBefore;
        int          strobesBefore;
        int          pulsesBefore;
        int          gap;
        logic [31:0] r;
        errsBefore    = monErrs + tbErrs;
        strobesBefore = strobeTotal;
        pulsesBefore  = pulseTotal;
        testName      = "gappedRandom";
        repeat (GAP_COUNT) begin
            drawRandom(r);
            sendMask(`CMP_DIMM'(r >> (32 - `CMP_DIMM)));
            gap = int'(r[15:0]) % (MAX_GAP + 1);
            idleCycles(gap);
        end
        drainResults();
        if (pulseTotal - pulsesBefore != strobeTotal - strobesBefore) begin
            tbErrs++;
            $display("%s: %0d strobes gave %0d outVld pulses", testName,
                     strobeTotal - strobesBefore, pulseTotal - pulsesBefore);
        end
        finishTest(errsBefore);
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        idleAfterReset();
        directedMasks();
        sparseMasks();
        backToBackRandom();
        gappedRandom();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, monErrs + tbErrs);
        if (testsFailed == 0 && monErrs + tbErrs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("watchdog expired after %0d cycles in %s", LIMIT_CYCLES, testName);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
cmpPkg.sv
outlierTagger.sv
compactStage.sv
indexCollector.sv
outlierCompactor.sv
tbOutlierCompactor.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tbOutlierCompactor -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1
